//--- source/rx_pkg.sv
`default_nettype none

package rx_pkg;

   localparam int ADC_W        = 14;
   localparam int SMP_W        = 16;
   localparam int SCALE_W      = 16;
   localparam int GAIN_SHIFT   = 14;
   localparam int CIC_STAGES   = 3;
   localparam int MAX_LOG_RATE = 6;
   localparam int CIC_W        = SMP_W + CIC_STAGES * MAX_LOG_RATE;

   localparam int ADR_W = 3;
   localparam int DAT_W = 32;

   localparam logic [ADR_W-1:0] REG_SCALE = 3'd0;
   localparam logic [ADR_W-1:0] REG_DECIM = 3'd1;
   localparam logic [ADR_W-1:0] REG_MUX   = 3'd2;
   localparam logic [ADR_W-1:0] REG_OFS_A = 3'd3;
   localparam logic [ADR_W-1:0] REG_OFS_B = 3'd4;

   localparam logic signed [SCALE_W-1:0] SCALE_UNITY = 16'sd16384;

   typedef enum logic [1:0] {
      SEL_OWN      = 2'd0,
      SEL_OTHER    = 2'd1,
      SEL_ZERO     = 2'd2,
      SEL_ZERO_ALT = 2'd3
   } mux_sel_e;

   typedef struct packed {
      logic signed [SCALE_W-1:0] scale_i;
      logic signed [SCALE_W-1:0] scale_q;
      logic [2:0]                log_rate;  // 0..6
      mux_sel_e                  sel_i;
      mux_sel_e                  sel_q;
      logic signed [ADC_W-1:0]   ofs_a;
      logic signed [ADC_W-1:0]   ofs_b;
   } rx_settings_t;

   typedef struct packed {
      logic signed [SMP_W-1:0] i;
      logic signed [SMP_W-1:0] q;
   } iq_t;

endpackage

`default_nettype wire

//--- source/rx_settings_wb.sv
`default_nettype none

module rx_settings_wb import rx_pkg::*; (
   input  logic             clk,
   input  logic             rst,
   input  logic             cyc,
   input  logic             stb,
   input  logic             we,
   input  logic [ADR_W-1:0] adr,
   input  logic [DAT_W-1:0] dat_w,
   output logic [DAT_W-1:0] dat_r,
   output logic             ack,
   output rx_settings_t     settings,
   output logic             decim_restart
);

   typedef enum logic {S_IDLE, S_ACK} wb_state_e;

   wb_state_e        state;
   logic             req;
   logic [2:0]       rate_wr;
   logic [DAT_W-1:0] rd_data;

   assign req = cyc && stb && (state == S_IDLE);
   assign ack = (state == S_ACK);

   assign rate_wr = (dat_w[2:0] > 3'(MAX_LOG_RATE)) ? 3'(MAX_LOG_RATE) : dat_w[2:0];

   always_comb begin
      rd_data = '0;
      case (adr)
         REG_SCALE: rd_data = {settings.scale_i, settings.scale_q};
         REG_DECIM: rd_data[2:0] = settings.log_rate;
         REG_MUX:   rd_data[3:0] = {settings.sel_q, settings.sel_i};
         REG_OFS_A: rd_data[ADC_W-1:0] = settings.ofs_a;
         REG_OFS_B: rd_data[ADC_W-1:0] = settings.ofs_b;
         default:   rd_data = '0;  // unmapped reads zero
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state            <= S_IDLE;
         decim_restart    <= 1'b0;
         settings         <= '0;
         settings.scale_i <= SCALE_UNITY;
         settings.scale_q <= SCALE_UNITY;
      end else begin
         decim_restart <= req && we && (adr == REG_DECIM);
         case (state)
            S_IDLE: if (req) state <= S_ACK;
            default: state <= S_IDLE;  // single-cycle ack
         endcase
         if (req && we) begin
            case (adr)
               REG_SCALE: {settings.scale_i, settings.scale_q} <= dat_w;
               REG_DECIM: settings.log_rate <= rate_wr;
               REG_MUX: begin
                  settings.sel_i <= mux_sel_e'(dat_w[1:0]);
                  settings.sel_q <= mux_sel_e'(dat_w[3:2]);
               end
               REG_OFS_A: settings.ofs_a <= dat_w[ADC_W-1:0];
               REG_OFS_B: settings.ofs_b <= dat_w[ADC_W-1:0];
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (req) dat_r <= rd_data;  // held through the ack cycle
   end

   // master must keep the request up until it sees ack
   a_ack_in_cycle: assert property (@(posedge clk) disable iff (rst) ack |-> (cyc && stb));

endmodule

`default_nettype wire

//--- source/rx_dcoffset.sv
`default_nettype none

module rx_dcoffset import rx_pkg::*; (
   input  logic                    clk,
   input  logic                    rst,
   input  logic signed [ADC_W-1:0] adc_in,
   input  logic signed [ADC_W-1:0] ofs,
   output logic signed [ADC_W-1:0] adc_out
);

   localparam logic signed [ADC_W-1:0] ADC_MAX = {1'b0, {(ADC_W-1){1'b1}}};
   localparam logic signed [ADC_W-1:0] ADC_MIN = {1'b1, {(ADC_W-1){1'b0}}};

   logic signed [ADC_W:0]   diff;
   logic signed [ADC_W-1:0] clipped;

   assign diff = {adc_in[ADC_W-1], adc_in} - {ofs[ADC_W-1], ofs};

   always_comb begin
      if (diff[ADC_W] != diff[ADC_W-1]) begin
         clipped = diff[ADC_W] ? ADC_MIN : ADC_MAX;  // out of 14-bit range
      end else begin
         clipped = diff[ADC_W-1:0];
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         adc_out <= '0;
      end else begin
         adc_out <= clipped;
      end
   end

endmodule

`default_nettype wire

//--- source/rx_front_end.sv
`default_nettype none

module rx_front_end import rx_pkg::*; (
   input  logic                    clk,
   input  logic                    rst,
   input  logic signed [ADC_W-1:0] adc_a,
   input  logic signed [ADC_W-1:0] adc_b,
   input  rx_settings_t            settings,
   output iq_t                     iq
);

   localparam int PROD_W = ADC_W + SCALE_W;

   logic signed [ADC_W-1:0] a_ofs, b_ofs;
   logic signed [ADC_W-1:0] path_i, path_q;

   // rounds half up, then clips to the sample width
   function automatic logic signed [SMP_W-1:0] apply_gain(
      input logic signed [ADC_W-1:0]   x,
      input logic signed [SCALE_W-1:0] g
   );
      logic signed [PROD_W-1:0]          prod;
      logic signed [PROD_W:0]            rnd;
      logic signed [PROD_W-GAIN_SHIFT:0] shf;
      prod = x * g;
      rnd  = (PROD_W+1)'(prod) + (PROD_W+1)'(2 ** (GAIN_SHIFT - 1));
      shf  = rnd[PROD_W:GAIN_SHIFT];
      if (shf[PROD_W-GAIN_SHIFT:SMP_W-1] != {(PROD_W-GAIN_SHIFT-SMP_W+2){shf[PROD_W-GAIN_SHIFT]}})
         return shf[PROD_W-GAIN_SHIFT] ? {1'b1, {(SMP_W-1){1'b0}}} : {1'b0, {(SMP_W-1){1'b1}}};
      return shf[SMP_W-1:0];
   endfunction

   rx_dcoffset dcoffset_a (
      .clk     (clk),
      .rst     (rst),
      .adc_in  (adc_a),
      .ofs     (settings.ofs_a),
      .adc_out (a_ofs)
   );

   rx_dcoffset dcoffset_b (
      .clk     (clk),
      .rst     (rst),
      .adc_in  (adc_b),
      .ofs     (settings.ofs_b),
      .adc_out (b_ofs)
   );

   always_comb begin
      case (settings.sel_i)
         SEL_OWN:   path_i = a_ofs;
         SEL_OTHER: path_i = b_ofs;
         default:   path_i = '0;
      endcase
      case (settings.sel_q)
         SEL_OWN:   path_q = b_ofs;
         SEL_OTHER: path_q = a_ofs;
         default:   path_q = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         iq <= '0;
      end else begin
         iq.i <= apply_gain(path_i, settings.scale_i);
         iq.q <= apply_gain(path_q, settings.scale_q);
      end
   end

endmodule

`default_nettype wire

//--- source/decim_strober.sv
`default_nettype none

module decim_strober import rx_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  logic       run,
   input  logic       restart,
   input  logic [2:0] log_rate,
   output logic       dec_stb
);

   logic [MAX_LOG_RATE:0]   span;
   logic [MAX_LOG_RATE-1:0] reload, cnt;

   assign span    = (MAX_LOG_RATE+1)'(1) << log_rate;
   assign reload  = span[MAX_LOG_RATE-1:0] - 1'b1;  // 2^log_rate - 1, wraps to 63 for 64
   assign dec_stb = run && !restart && (cnt == '0);

   always_ff @(posedge clk) begin
      if (rst) begin
         cnt <= '0;
      end else if (restart) begin
         cnt <= reload;
      end else if (run) begin
         cnt <= (cnt == '0) ? reload : cnt - 1'b1;
      end
   end

   // log_rate only moves together with restart
   a_cnt_in_span: assert property (@(posedge clk) disable iff (rst)
      !restart |-> cnt <= reload);

endmodule

`default_nettype wire

//--- source/cic_decim.sv
`default_nettype none

module cic_decim import rx_pkg::*; (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    run,
   input  logic                    restart,
   input  logic                    dec_stb,
   input  logic [2:0]              log_rate,
   input  logic signed [SMP_W-1:0] din,
   output logic signed [SMP_W-1:0] dout,
   output logic                    out_stb
);

   logic signed [CIC_W-1:0] integ [CIC_STAGES];
   logic signed [CIC_W-1:0] dly   [CIC_STAGES];
   logic signed [CIC_W-1:0] comb  [CIC_STAGES+1];
   logic signed [CIC_W-1:0] comb_out;
   logic                    comb_vld;

   logic [4:0]              shift;
   logic signed [CIC_W:0]   half, rnd, shifted;
   logic signed [SMP_W-1:0] clipped;

   always_comb begin
      comb[0] = integ[CIC_STAGES-1];
      for (int k = 0; k < CIC_STAGES; k++) begin
         comb[k+1] = comb[k] - dly[k];
      end
   end

   // gain is 2^(3*log_rate), undone exactly by the shift
   assign shift = 5'(CIC_STAGES) * 5'(log_rate);

   always_comb begin
      half = '0;
      if (shift != '0) half[shift-1] = 1'b1;
      rnd     = {comb_out[CIC_W-1], comb_out} + half;
      shifted = rnd >>> shift;
      if (shifted[CIC_W:SMP_W-1] != {(CIC_W-SMP_W+2){shifted[CIC_W]}}) begin
         clipped = shifted[CIC_W] ? {1'b1, {(SMP_W-1){1'b0}}} : {1'b0, {(SMP_W-1){1'b1}}};
      end else begin
         clipped = shifted[SMP_W-1:0];
      end
   end

   always_ff @(posedge clk) begin
      if (rst || restart) begin
         for (int k = 0; k < CIC_STAGES; k++) begin
            integ[k] <= '0;
            dly[k]   <= '0;
         end
         comb_vld <= 1'b0;
         out_stb  <= 1'b0;
      end else begin
         if (run) begin
            integ[0] <= integ[0] + CIC_W'(din);
            for (int k = 1; k < CIC_STAGES; k++) begin
               integ[k] <= integ[k] + integ[k-1];
            end
         end
         if (dec_stb) begin
            for (int k = 0; k < CIC_STAGES; k++) begin
               dly[k] <= comb[k];
            end
         end
         comb_vld <= dec_stb;
         out_stb  <= comb_vld;
      end
   end

   always_ff @(posedge clk) begin
      if (dec_stb) comb_out <= comb[CIC_STAGES];
      if (comb_vld) dout <= clipped;
   end

   // accumulator width only covers rates up to MAX_LOG_RATE
   a_rate_legal: assert property (@(posedge clk) disable iff (rst)
      log_rate <= 3'(MAX_LOG_RATE));

endmodule

`default_nettype wire

//--- source/dsp_rx_core.sv
`default_nettype none

module dsp_rx_core import rx_pkg::*; (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    cyc,
   input  logic                    stb,
   input  logic                    we,
   input  logic [ADR_W-1:0]        adr,
   input  logic [DAT_W-1:0]        dat_w,
   output logic [DAT_W-1:0]        dat_r,
   output logic                    ack,
   input  logic signed [ADC_W-1:0] adc_a,
   input  logic signed [ADC_W-1:0] adc_b,
   input  logic                    run,
   output iq_t                     sample,
   output logic                    strobe
);

   rx_settings_t settings;
   iq_t          front_iq;
   logic         decim_restart;
   logic         dec_stb;

   rx_settings_wb settings_wb (
      .clk           (clk),
      .rst           (rst),
      .cyc           (cyc),
      .stb           (stb),
      .we            (we),
      .adr           (adr),
      .dat_w         (dat_w),
      .dat_r         (dat_r),
      .ack           (ack),
      .settings      (settings),
      .decim_restart (decim_restart)
   );

   rx_front_end front_end (
      .clk      (clk),
      .rst      (rst),
      .adc_a    (adc_a),
      .adc_b    (adc_b),
      .settings (settings),
      .iq       (front_iq)
   );

   decim_strober strober (
      .clk      (clk),
      .rst      (rst),
      .run      (run),
      .restart  (decim_restart),
      .log_rate (settings.log_rate),
      .dec_stb  (dec_stb)
   );

   cic_decim cic_i (
      .clk      (clk),
      .rst      (rst),
      .run      (run),
      .restart  (decim_restart),
      .dec_stb  (dec_stb),
      .log_rate (settings.log_rate),
      .din      (front_iq.i),
      .dout     (sample.i),
      .out_stb  (strobe)
   );

   cic_decim cic_q (
      .clk      (clk),
      .rst      (rst),
      .run      (run),
      .restart  (decim_restart),
      .dec_stb  (dec_stb),
      .log_rate (settings.log_rate),
      .din      (front_iq.q),
      .dout     (sample.q),
      .out_stb  ()  // same timing as the I path
   );

endmodule

`default_nettype wire

//--- sim/dsp_rx_core_tb.sv
`default_nettype none

module dsp_rx_core_tb import rx_pkg::*; ();

   localparam int MAX_CYCLES = 20000;  // well above the total test length
   localparam int SETTLE     = 8;      // strobes before a sample is trusted

   logic                    clk, rst, cyc, stb, we, run, strobe, ack;
   logic [ADR_W-1:0]        adr;
   logic [DAT_W-1:0]        dat_w, dat_r;
   logic signed [ADC_W-1:0] adc_a, adc_b;
   iq_t                     sample;

   int seed = 32'h214c;
   int cycle = 0;
   int checks = 0;
   int errors = 0;
   int tests = 0;
   int sh_a, sh_b, sh_si, sh_sq, sh_seli, sh_selq, sh_ofa, sh_ofb;

   dsp_rx_core dsp_rx_core_i (
      .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w),
      .dat_r(dat_r), .ack(ack), .adc_a(adc_a), .adc_b(adc_b), .run(run),
      .sample(sample), .strobe(strobe)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle >= MAX_CYCLES) begin
         $display("timeout: no result after %0d cycles", cycle);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   function automatic int sat(int v, int w);
      int hi;
      int lo;
      hi = (1 << (w - 1)) - 1;
      lo = -(1 << (w - 1));
      if (v > hi) return hi;
      if (v < lo) return lo;
      return v;
   endfunction

   // crossbar pick, then gain with round half up
   function automatic int path_value(int own, int other, int sel, int scale);
      int x;
      case (sel)
         0: x = own;
         1: x = other;
         default: x = 0;
      endcase
      return sat((x * scale + (1 << (GAIN_SHIFT - 1))) >>> GAIN_SHIFT, SMP_W);
   endfunction

   function automatic int rand14();
      logic [31:0] r;
      r = $random(seed);
      return int'($signed(r[ADC_W-1:0]));
   endfunction

   task automatic compare(input string name, input int exp, input int got);
      checks++;
      assert (got == exp) else begin
         errors++;
         $display("Fail %s: expected %0d, actual %0d", name, exp, got);
      end
   endtask

   task automatic wb_cycle(input logic wr, input int a, input logic [31:0] d,
                           output logic [31:0] r);
      @(posedge clk);
      cyc <= 1'b1;
      stb <= 1'b1;
      we <= wr;
      adr <= ADR_W'(a);
      dat_w <= d;
      @(negedge clk);
      while (!ack) @(negedge clk);
      r = dat_r;
      @(posedge clk);
      cyc <= 1'b0;
      stb <= 1'b0;
      we <= 1'b0;
   endtask

   task automatic wb_write(input int a, input logic [31:0] d);
      logic [31:0] unused;
      wb_cycle(1'b1, a, d, unused);
   endtask

   task automatic wb_read(input int a, output logic [31:0] r);
      wb_cycle(1'b0, a, '0, r);
   endtask

   // decim last, its restart then starts from the new settings
   task automatic set_all(int si, int sq, int rate, int seli, int selq, int ofa, int ofb);
      wb_write(REG_SCALE, {16'(si), 16'(sq)});
      wb_write(REG_MUX, {28'd0, 2'(selq), 2'(seli)});
      wb_write(REG_OFS_A, 32'(ofa));
      wb_write(REG_OFS_B, 32'(ofb));
      wb_write(REG_DECIM, 32'(rate));
      sh_si = si;
      sh_sq = sq;
      sh_seli = seli;
      sh_selq = selq;
      sh_ofa = ofa;
      sh_ofb = ofb;
   endtask

   task automatic drive_adc(int a, int b);
      @(posedge clk);
      adc_a <= ADC_W'(a);
      adc_b <= ADC_W'(b);
      sh_a = a;
      sh_b = b;
   endtask

   task automatic wait_strobes(int n);
      int seen;
      seen = 0;
      while (seen < n) begin
         @(negedge clk);
         if (strobe) seen++;
      end
   endtask

   task automatic strobe_gap(output int gap);
      int t0;
      wait_strobes(1);
      t0 = cycle;
      wait_strobes(1);
      gap = cycle - t0;
   endtask

   task automatic check_settled(string name);
      int ca;
      int cb;
      wait_strobes(SETTLE);
      ca = sat(sh_a - sh_ofa, ADC_W);
      cb = sat(sh_b - sh_ofb, ADC_W);
      compare({name, " i"}, path_value(ca, cb, sh_seli, sh_si), int'(sample.i));
      compare({name, " q"}, path_value(cb, ca, sh_selq, sh_sq), int'(sample.q));
   endtask

   task automatic finish_test(string name, int errs_before);
      tests++;
      $display("test %s done, %0d errors", name, errors - errs_before);
   endtask

   task automatic test_readback();
      logic [31:0] v [5];
      logic [31:0] r;
      logic [31:0] exp;
      int e0;
      e0 = errors;
      for (int k = 0; k < 5; k++) begin
         v[k] = $random(seed);
         wb_write(k, v[k]);
      end
      for (int k = 0; k < 5; k++) begin
         case (k)
            0: exp = v[0];
            1: exp = (v[1][2:0] > 3'd6) ? 32'd6 : {29'd0, v[1][2:0]};
            2: exp = {28'd0, v[2][3:0]};
            default: exp = {18'd0, v[k][13:0]};
         endcase
         wb_read(k, r);
         compare("readback", int'(exp), int'(r));
      end
      wb_write(REG_DECIM, 32'd7);  // clamps to the top rate
      wb_read(REG_DECIM, r);
      compare("readback clamp", 6, int'(r));
      wb_write(5, 32'hffff_ffff);
      wb_read(5, r);
      compare("readback unmapped", 0, int'(r));
      finish_test("readback", e0);
   endtask

   task automatic test_passthrough();
      int e0;
      e0 = errors;
      set_all(16384, 16384, 0, 0, 0, 0, 0);
      for (int k = 0; k < 3; k++) begin
         drive_adc(rand14(), rand14());
         check_settled("passthrough");
      end
      for (int k = 0; k < 8; k++) begin
         @(negedge clk);
         compare("passthrough strobe", 1, int'(strobe));
      end
      finish_test("passthrough", e0);
   endtask

   task automatic test_offset();
      int e0;
      e0 = errors;
      set_all(16384, 16384, 0, 0, 0, -2000, 3000);
      drive_adc(7936, -7000);  // both clip
      check_settled("offset clip");
      set_all(16384, 16384, 0, 0, 0, rand14() / 2, rand14() / 2);
      drive_adc(rand14() / 2, rand14() / 2);
      check_settled("offset");
      finish_test("offset", e0);
   endtask

   task automatic test_crossbar();
      int e0;
      e0 = errors;
      drive_adc(rand14(), rand14());
      set_all(16384, 16384, 0, 1, 1, 0, 0);  // swapped
      check_settled("crossbar swap");
      set_all(16384, 16384, 0, 2, 3, 0, 0);
      check_settled("crossbar zero");
      set_all(16384, 16384, 0, 0, 1, 100, -100);
      check_settled("crossbar a to both");
      finish_test("crossbar", e0);
   endtask

   task automatic test_gain();
      int e0;
      e0 = errors;
      drive_adc(rand14(), rand14());
      set_all(8192, -16384, 0, 0, 0, 0, 0);
      check_settled("gain half neg");
      drive_adc(-8192, 8191);
      set_all(-32768, 32767, 0, 0, 0, 0, 0);
      check_settled("gain large");
      drive_adc(rand14(), rand14());
      set_all(-32768, 32767, 0, 0, 0, 0, -5);
      check_settled("gain large rand");
      finish_test("gain", e0);
   endtask

   task automatic test_decimation();
      int e0;
      int gap;
      int seen;
      e0 = errors;
      drive_adc(rand14(), rand14());
      set_all(16384, 16384, 3, 0, 0, 0, 0);
      check_settled("decim 8");
      strobe_gap(gap);
      compare("decim 8 spacing", 8, gap);
      @(posedge clk);
      run <= 1'b0;
      repeat (4) @(negedge clk);  // lets the CIC pipeline drain
      seen = 0;
      repeat (40) begin
         @(negedge clk);
         if (strobe) seen++;
      end
      compare("decim halted strobes", 0, seen);
      @(posedge clk);
      run <= 1'b1;
      set_all(16384, 16384, 6, 0, 0, 0, 0);
      check_settled("decim 64");
      strobe_gap(gap);
      compare("decim 64 spacing", 64, gap);
      finish_test("decimation", e0);
   endtask

   initial begin
      rst = 1'b1;
      cyc = 1'b0;
      stb = 1'b0;
      we = 1'b0;
      adr = '0;
      dat_w = '0;
      adc_a = '0;
      adc_b = '0;
      run = 1'b0;
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      run <= 1'b1;
      test_readback();
      test_passthrough();
      test_offset();
      test_crossbar();
      test_gain();
      test_decimation();
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- dsp_rx_core.f
source/rx_pkg.sv
source/rx_settings_wb.sv
source/rx_dcoffset.sv
source/rx_front_end.sv
source/decim_strober.sv
source/cic_decim.sv
source/dsp_rx_core.sv
sim/dsp_rx_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= dsp_rx_core_tb
FILELIST  ?= dsp_rx_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= PASS: all tests

SIM_BIN = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
